//--- all.f
+incdir+include
source/gnn_ctrl_pkg.sv
source/gnn_data_pkg.sv
source/edge_pe_fsm.sv
source/neighbor_counter.sv
source/neighbor_id_buffer.sv
source/aggr_bank.sv
source/edge_pe_top.sv
test/memory_model.sv
test/edge_pe_tb.sv

//--- include/gnn_defines.svh
`ifndef GNN_DEFINES_SVH
`define GNN_DEFINES_SVH

// node ids and neighbor lists
`define GNN_NODE_BITS    7
`define GNN_MAX_DEGREE   16

// feature beats
`define GNN_LANE_BITS    8
`define GNN_LANES        2
`define GNN_SUM_BITS     16  // accumulated lane, wraps

// replay iterations, also the width of the replay mask
`define GNN_REPLAY_ITERS 4

`endif

//--- source/aggr_bank.sv
`timescale 1ns/100ps
`include "gnn_defines.svh"

module aggr_bank (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    acc_clear,
    input  logic                    acc_add,
    input  logic                    acc_sel_prev,
    input  gnn_data_pkg::fv_lane_t  fv_lane0,
    input  gnn_data_pkg::fv_lane_t  fv_lane1,
    input  gnn_data_pkg::lane_sum_t prev_lane0,
    input  gnn_data_pkg::lane_sum_t prev_lane1,
    input  logic                    done_pulse,
    input  logic                    wb_pulse,
    input  gnn_data_pkg::node_id_t  target_node,
    output logic                    done_aggr,
    output logic                    wb_en,
    output gnn_data_pkg::node_id_t  result_node,
    output gnn_data_pkg::lane_sum_t result_lane0,
    output gnn_data_pkg::lane_sum_t result_lane1
);

    gnn_data_pkg::lane_sum_t sum    [`GNN_LANES];
    gnn_data_pkg::lane_sum_t addend [`GNN_LANES];

    // previous output is already a full-width sum
    assign addend[0] = acc_sel_prev ? prev_lane0 : gnn_data_pkg::lane_sum_t'(fv_lane0);
    assign addend[1] = acc_sel_prev ? prev_lane1 : gnn_data_pkg::lane_sum_t'(fv_lane1);

    always_ff @(posedge clk) begin
        if (reset || acc_clear) begin
            for (int i = 0; i < `GNN_LANES; i++)
                sum[i] <= '0;
        end else if (acc_add) begin
            for (int i = 0; i < `GNN_LANES; i++)
                sum[i] <= sum[i] + addend[i];  // wraps at 16 bits
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done_aggr <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            done_aggr <= done_pulse;
            wb_en     <= wb_pulse;
        end
    end

    always_ff @(posedge clk) begin
        if (done_pulse || wb_pulse) result_node <= target_node;
    end

    assign result_lane0 = sum[0];
    assign result_lane1 = sum[1];

    assert property (@(posedge clk) disable iff (reset) !(acc_add && acc_clear));

endmodule

//--- source/edge_pe_fsm.sv
`timescale 1ns/100ps
`include "gnn_defines.svh"

module edge_pe_fsm #(
    parameter logic [3:0] pe_tag = 4'd0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        task_valid,
    input  gnn_data_pkg::task_packet_t  task_packet,
    input  gnn_data_pkg::replay_iter_t  cur_replay_iter,
    input  logic                        arb_grant,
    input  logic                        nbr_sos,
    input  logic                        nbr_eos,
    input  gnn_data_pkg::nbr_count_t    nbr_num,
    input  logic                        fetch_last,
    input  gnn_data_pkg::node_id_t      rd_id,
    input  logic                        fv_sos,
    input  logic                        fv_eos,
    input  logic                        out_grant,
    input  logic                        prev_sos,
    input  logic                        prev_eos,
    input  logic                        wb_grant,
    output logic                        idle,
    output logic                        arb_req,
    output logic [3:0]                  arb_pe_tag,
    output gnn_ctrl_pkg::req_type_t     arb_req_type,
    output gnn_data_pkg::node_id_t      arb_node_id,
    output logic                        out_req,
    output gnn_data_pkg::node_id_t      out_node_id,
    output logic                        wb_req,
    output logic                        imem_valid,
    output gnn_data_pkg::task_packet_t  imem_packet,
    output logic                        nbr_wr,
    output logic                        nbr_clear,
    output logic                        fv_advance,
    output logic                        acc_clear,
    output logic                        acc_add,
    output logic                        acc_sel_prev,
    output logic                        done_pulse,
    output logic                        wb_pulse,
    output gnn_data_pkg::node_id_t      target_node
);

    gnn_ctrl_pkg::pe_state_t    state, next_state, after_fetch;
    gnn_data_pkg::task_packet_t task_q;
    gnn_data_pkg::replay_mask_t task_mask, below_iter, at_iter;
    logic                       prev_needed, replay_needed;
    logic                       in_stream, beat_sos, beat_eos, in_fetch;

    assign target_node = task_q[`GNN_NODE_BITS-1:0];
    assign task_mask   = task_q[$bits(task_q)-1 -: `GNN_REPLAY_ITERS];
    assign imem_packet = task_q;  // replayed unchanged

    // mask bits below and above the current iteration
    assign at_iter       = gnn_data_pkg::replay_mask_t'(1) << cur_replay_iter;
    assign below_iter    = at_iter - gnn_data_pkg::replay_mask_t'(1);
    assign prev_needed   = |(task_mask & below_iter);
    assign replay_needed = |(task_mask & ~below_iter & ~at_iter);
    assign after_fetch   = prev_needed ? gnn_ctrl_pkg::req_prev_out : gnn_ctrl_pkg::complete;

    // request levels straight from the state
    assign idle         = state == gnn_ctrl_pkg::idle;
    assign arb_req      = state == gnn_ctrl_pkg::req_nbr_id || state == gnn_ctrl_pkg::req_nbr_fv;
    assign arb_pe_tag   = pe_tag;
    assign arb_req_type = state == gnn_ctrl_pkg::req_nbr_fv ? gnn_ctrl_pkg::req_feature
                                                            : gnn_ctrl_pkg::req_nbr_list;
    assign arb_node_id  = state == gnn_ctrl_pkg::req_nbr_fv ? rd_id : target_node;
    assign out_req      = state == gnn_ctrl_pkg::req_prev_out;
    assign out_node_id  = target_node;
    assign wb_req       = state == gnn_ctrl_pkg::wb_wait;

    // beat tracking shared by feature and previous-output streams
    assign acc_sel_prev = state == gnn_ctrl_pkg::wait_prev_out;
    assign in_fetch     = state == gnn_ctrl_pkg::wait_nbr_fv || acc_sel_prev;
    assign beat_sos     = acc_sel_prev ? prev_sos : fv_sos;
    assign beat_eos     = acc_sel_prev ? prev_eos : fv_eos;
    assign acc_add      = in_fetch && (beat_sos || beat_eos || in_stream);

    always_comb begin
        next_state = state;
        nbr_wr     = 1'b0;
        nbr_clear  = 1'b0;
        fv_advance = 1'b0;
        acc_clear  = 1'b0;
        done_pulse = 1'b0;
        wb_pulse   = 1'b0;
        case (state)
            gnn_ctrl_pkg::idle: if (task_valid) begin
                nbr_clear  = 1'b1;
                acc_clear  = 1'b1;
                next_state = gnn_ctrl_pkg::req_nbr_id;
            end
            gnn_ctrl_pkg::req_nbr_id: if (arb_grant) next_state = gnn_ctrl_pkg::wait_nbr_id;
            gnn_ctrl_pkg::wait_nbr_id: if (nbr_sos) begin
                nbr_wr = 1'b1;
                if (!nbr_eos)
                    next_state = gnn_ctrl_pkg::stream_nbr_id;
                else if (nbr_num == '0)
                    next_state = after_fetch;  // empty list has nothing to fetch
                else
                    next_state = gnn_ctrl_pkg::req_nbr_fv;
            end
            gnn_ctrl_pkg::stream_nbr_id: begin
                nbr_wr = 1'b1;
                if (nbr_eos) next_state = gnn_ctrl_pkg::req_nbr_fv;
            end
            gnn_ctrl_pkg::req_nbr_fv: if (arb_grant) begin
                fv_advance = 1'b1;
                next_state = gnn_ctrl_pkg::wait_nbr_fv;
            end
            gnn_ctrl_pkg::wait_nbr_fv: if (fv_eos) begin
                next_state = fetch_last ? after_fetch : gnn_ctrl_pkg::req_nbr_fv;
            end
            gnn_ctrl_pkg::req_prev_out: if (out_grant) next_state = gnn_ctrl_pkg::wait_prev_out;
            gnn_ctrl_pkg::wait_prev_out: if (prev_eos) next_state = gnn_ctrl_pkg::complete;
            gnn_ctrl_pkg::complete: if (replay_needed) begin
                next_state = gnn_ctrl_pkg::wb_wait;
            end else begin
                done_pulse = 1'b1;
                next_state = gnn_ctrl_pkg::idle;
            end
            gnn_ctrl_pkg::wb_wait: if (wb_grant) begin
                wb_pulse   = 1'b1;
                next_state = gnn_ctrl_pkg::idle;
            end
            default: next_state = gnn_ctrl_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= gnn_ctrl_pkg::idle;
            in_stream  <= 1'b0;
            imem_valid <= 1'b0;
        end else begin
            state      <= next_state;
            in_stream  <= in_fetch && (in_stream || beat_sos) && !beat_eos;
            imem_valid <= wb_pulse;
        end
    end

    always_ff @(posedge clk) begin
        if (idle && task_valid) task_q <= task_packet;
    end

    // node id held until the arbiter answers
    assert property (@(posedge clk) disable iff (reset)
        arb_req && !arb_grant |=> arb_req && $stable(arb_node_id));

endmodule

//--- source/edge_pe_top.sv
`timescale 1ns/100ps

module edge_pe_top #(
    parameter logic [3:0] pe_tag = 4'd0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        task_valid,
    input  gnn_data_pkg::task_packet_t  task_packet,
    input  gnn_data_pkg::replay_iter_t  cur_replay_iter,
    input  logic                        arb_grant,
    input  logic                        nbr_sos,
    input  logic                        nbr_eos,
    input  gnn_data_pkg::nbr_count_t    nbr_num,
    input  gnn_data_pkg::node_id_t      nbr_id_lo,
    input  gnn_data_pkg::node_id_t      nbr_id_hi,
    input  logic                        fv_sos,
    input  logic                        fv_eos,
    input  gnn_data_pkg::fv_lane_t      fv_lane0,
    input  gnn_data_pkg::fv_lane_t      fv_lane1,
    input  logic                        out_grant,
    input  logic                        prev_sos,
    input  logic                        prev_eos,
    input  gnn_data_pkg::lane_sum_t     prev_lane0,
    input  gnn_data_pkg::lane_sum_t     prev_lane1,
    input  logic                        wb_grant,
    output logic                        idle,
    output logic                        arb_req,
    output logic [3:0]                  arb_pe_tag,
    output gnn_ctrl_pkg::req_type_t     arb_req_type,
    output gnn_data_pkg::node_id_t      arb_node_id,
    output logic                        out_req,
    output gnn_data_pkg::node_id_t      out_node_id,
    output logic                        wb_req,
    output logic                        imem_valid,
    output gnn_data_pkg::task_packet_t  imem_packet,
    output logic                        done_aggr,
    output logic                        wb_en,
    output gnn_data_pkg::node_id_t      result_node,
    output gnn_data_pkg::lane_sum_t     result_lane0,
    output gnn_data_pkg::lane_sum_t     result_lane1
);

    logic                     nbr_wr, nbr_clear, fv_advance, fetch_last;
    logic                     acc_clear, acc_add, acc_sel_prev, done_pulse, wb_pulse;
    gnn_data_pkg::nbr_count_t wr_ptr, rd_ptr;
    gnn_data_pkg::node_id_t   rd_id, target_node;

    edge_pe_fsm #(.pe_tag(pe_tag)) u_fsm (
        .clk(clk), .reset(reset),
        .task_valid(task_valid), .task_packet(task_packet),
        .cur_replay_iter(cur_replay_iter), .arb_grant(arb_grant),
        .nbr_sos(nbr_sos), .nbr_eos(nbr_eos), .nbr_num(nbr_num),
        .fetch_last(fetch_last), .rd_id(rd_id),
        .fv_sos(fv_sos), .fv_eos(fv_eos), .out_grant(out_grant),
        .prev_sos(prev_sos), .prev_eos(prev_eos), .wb_grant(wb_grant),
        .idle(idle), .arb_req(arb_req), .arb_pe_tag(arb_pe_tag),
        .arb_req_type(arb_req_type), .arb_node_id(arb_node_id),
        .out_req(out_req), .out_node_id(out_node_id), .wb_req(wb_req),
        .imem_valid(imem_valid), .imem_packet(imem_packet),
        .nbr_wr(nbr_wr), .nbr_clear(nbr_clear), .fv_advance(fv_advance),
        .acc_clear(acc_clear), .acc_add(acc_add), .acc_sel_prev(acc_sel_prev),
        .done_pulse(done_pulse), .wb_pulse(wb_pulse), .target_node(target_node)
    );

    neighbor_counter u_counter (
        .clk(clk), .reset(reset),
        .nbr_clear(nbr_clear), .nbr_wr(nbr_wr), .nbr_num(nbr_num),
        .fv_advance(fv_advance),
        .wr_ptr(wr_ptr), .rd_ptr(rd_ptr), .fetch_last(fetch_last)
    );

    neighbor_id_buffer u_buffer (
        .clk(clk), .reset(reset),
        .nbr_wr(nbr_wr), .wr_ptr(wr_ptr),
        .nbr_id_lo(nbr_id_lo), .nbr_id_hi(nbr_id_hi),
        .rd_ptr(rd_ptr), .rd_id(rd_id)
    );

    aggr_bank u_bank (
        .clk(clk), .reset(reset),
        .acc_clear(acc_clear), .acc_add(acc_add), .acc_sel_prev(acc_sel_prev),
        .fv_lane0(fv_lane0), .fv_lane1(fv_lane1),
        .prev_lane0(prev_lane0), .prev_lane1(prev_lane1),
        .done_pulse(done_pulse), .wb_pulse(wb_pulse), .target_node(target_node),
        .done_aggr(done_aggr), .wb_en(wb_en), .result_node(result_node),
        .result_lane0(result_lane0), .result_lane1(result_lane1)
    );

endmodule

//--- source/gnn_ctrl_pkg.sv
package gnn_ctrl_pkg;

    // edge element sequencing
    typedef enum logic [3:0] {
        idle,
        req_nbr_id,
        wait_nbr_id,
        stream_nbr_id,
        req_nbr_fv,
        wait_nbr_fv,    // covers the whole feature stream
        req_prev_out,
        wait_prev_out,
        complete,
        wb_wait
    } pe_state_t;

    // request kind on the shared bus arbiter
    typedef enum logic {
        req_nbr_list = 1'b0,
        req_feature  = 1'b1
    } req_type_t;

endpackage

//--- source/gnn_data_pkg.sv
`include "gnn_defines.svh"

package gnn_data_pkg;

    typedef logic [`GNN_NODE_BITS-1:0]    node_id_t;
    typedef logic [`GNN_LANE_BITS-1:0]    fv_lane_t;
    typedef logic [`GNN_SUM_BITS-1:0]     lane_sum_t;
    typedef logic [`GNN_REPLAY_ITERS-1:0] replay_mask_t;

    typedef logic [$clog2(`GNN_MAX_DEGREE+1)-1:0] nbr_count_t;  // 0 to 16
    typedef logic [$clog2(`GNN_REPLAY_ITERS)-1:0] replay_iter_t;

    // task packet, msb first: mask[13:10], priority[9:7], node[6:0]
    typedef logic [`GNN_REPLAY_ITERS+3+`GNN_NODE_BITS-1:0] task_packet_t;

endpackage

//--- source/neighbor_counter.sv
`timescale 1ns/100ps
`include "gnn_defines.svh"

module neighbor_counter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     nbr_clear,
    input  logic                     nbr_wr,
    input  gnn_data_pkg::nbr_count_t nbr_num,
    input  logic                     fv_advance,
    output gnn_data_pkg::nbr_count_t wr_ptr,
    output gnn_data_pkg::nbr_count_t rd_ptr,
    output logic                     fetch_last
);

    gnn_data_pkg::nbr_count_t nbr_total;

    always_ff @(posedge clk) begin
        if (reset || nbr_clear) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            nbr_total <= '0;
        end else begin
            if (nbr_wr) begin
                wr_ptr <= wr_ptr + 2'd2;  // two ids per beat
                if (wr_ptr == '0) nbr_total <= nbr_num;  // count rides on the first beat
            end
            if (fv_advance) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign fetch_last = rd_ptr == nbr_total;

    assert property (@(posedge clk) disable iff (reset) wr_ptr <= `GNN_MAX_DEGREE);

endmodule

//--- source/neighbor_id_buffer.sv
`timescale 1ns/100ps
`include "gnn_defines.svh"

module neighbor_id_buffer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     nbr_wr,
    input  gnn_data_pkg::nbr_count_t wr_ptr,
    input  gnn_data_pkg::node_id_t   nbr_id_lo,
    input  gnn_data_pkg::node_id_t   nbr_id_hi,
    input  gnn_data_pkg::nbr_count_t rd_ptr,
    output gnn_data_pkg::node_id_t   rd_id
);

    localparam int idx_bits = $clog2(`GNN_MAX_DEGREE);

    gnn_data_pkg::node_id_t ids [`GNN_MAX_DEGREE];
    logic [idx_bits-1:0]    wr_idx, wr_idx_hi, rd_idx;

    assign wr_idx    = wr_ptr[idx_bits-1:0];
    assign wr_idx_hi = wr_idx + 1'b1;
    assign rd_idx    = rd_ptr[idx_bits-1:0];  // wraps once the list is done

    always_ff @(posedge clk) begin
        if (nbr_wr && !reset) begin
            ids[wr_idx]    <= nbr_id_lo;
            ids[wr_idx_hi] <= nbr_id_hi;
        end
    end

    assign rd_id = ids[rd_idx];

endmodule

//--- test/edge_pe_tb.sv
`timescale 1ns/100ps
`include "gnn_defines.svh"

module edge_pe_tb;

    localparam logic [3:0] dut_tag = 4'd9;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic task_valid = 1'b0;
    gnn_data_pkg::task_packet_t task_packet = '0;
    gnn_data_pkg::replay_iter_t cur_replay_iter = '0;

    logic arb_grant, out_grant, wb_grant, nbr_sos, nbr_eos, fv_sos, fv_eos, prev_sos, prev_eos;
    logic idle, arb_req, out_req, wb_req, imem_valid, done_aggr, wb_en;
    logic [3:0]                 arb_pe_tag;
    gnn_ctrl_pkg::req_type_t    arb_req_type;
    gnn_data_pkg::nbr_count_t   nbr_num;
    gnn_data_pkg::node_id_t     nbr_id_lo, nbr_id_hi, arb_node_id, out_node_id, result_node;
    gnn_data_pkg::fv_lane_t     fv_lane0, fv_lane1;
    gnn_data_pkg::lane_sum_t    prev_lane0, prev_lane1, result_lane0, result_lane1;
    gnn_data_pkg::task_packet_t imem_packet;

    edge_pe_top #(.pe_tag(dut_tag)) u_dut (.*);
    memory_model u_mem (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            $display("sim failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("sim failed");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic set_list(input int node, input int count, input int first);
        int i;
        u_mem.nbr_cnt[node] = count;
        for (i = 0; i < count; i++)
            u_mem.nbr_tab[node][i] = (first + i * 11) % 128;
    endtask

    // reference sum straight from the tables
    function automatic gnn_data_pkg::lane_sum_t expected_sum(input int node, input int lane,
                                                            input logic with_prev);
        gnn_data_pkg::lane_sum_t sum;
        int i, b, nb;
        sum = '0;
        for (i = 0; i < u_mem.nbr_cnt[node]; i++) begin
            nb = u_mem.nbr_tab[node][i];
            for (b = 0; b < 3; b++)
                sum += lane == 0 ? u_mem.feat0[nb][b] : u_mem.feat1[nb][b];
        end
        if (with_prev)
            sum += lane == 0 ? u_mem.prev0[node] : u_mem.prev1[node];
        return sum;
    endfunction

    task automatic run_task(input int node, input logic [2:0] prio, input logic [3:0] mask,
                            input int iter);
        gnn_data_pkg::task_packet_t pkt;
        logic prev_exp, replay_exp;
        int i, cycles;
        pkt = {mask, prio, node[6:0]};
        prev_exp = 1'b0;
        replay_exp = 1'b0;
        for (i = 0; i < 4; i++) begin
            if (mask[i] && i < iter) prev_exp = 1'b1;
            if (mask[i] && i > iter) replay_exp = 1'b1;
        end
        cycles = 0;
        while (!idle) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > 200) report_timeout("idle");
        end
        u_mem.log_n = 0;
        u_mem.out_n = 0;
        u_mem.wb_n = 0;
        cur_replay_iter = iter;
        task_packet = pkt;
        task_valid = 1'b1;
        @(posedge clk);
        #2;
        task_valid = 1'b0;
        check_value("arb_req", arb_req, 1'b1);  // one cycle after dispatch
        check_value("arb_pe_tag", arb_pe_tag, dut_tag);
        cycles = 0;
        while (!done_aggr && !imem_valid) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > 3000) report_timeout("done_aggr or imem_valid");
        end
        check_value("done_aggr", done_aggr, !replay_exp);
        check_value("wb_en", wb_en, replay_exp);
        check_value("imem_valid", imem_valid, replay_exp);
        if (replay_exp) check_value("imem_packet", imem_packet, pkt);
        check_value("result_node", result_node, node);
        check_value("result_lane0", result_lane0, expected_sum(node, 0, prev_exp));
        check_value("result_lane1", result_lane1, expected_sum(node, 1, prev_exp));
        check_value("arb request count", u_mem.log_n, u_mem.nbr_cnt[node] + 1);
        check_value("arb_req_type", u_mem.log_type[0], gnn_ctrl_pkg::req_nbr_list);
        check_value("arb_node_id", u_mem.log_node[0], node);
        for (i = 1; i < u_mem.log_n; i++) begin
            check_value("arb_req_type", u_mem.log_type[i], gnn_ctrl_pkg::req_feature);
            check_value("arb_node_id", u_mem.log_node[i], u_mem.nbr_tab[node][i-1]);
        end
        check_value("out_req count", u_mem.out_n, prev_exp);
        if (prev_exp) check_value("out_node_id", u_mem.out_node, node);
        check_value("wb_req count", u_mem.wb_n, replay_exp);
        check_value("request hold errors", u_mem.hold_errs, 0);
    endtask

    task automatic test_reset_empty();
        check_value("idle and requests after reset",
                    {idle, arb_req, out_req, wb_req, done_aggr, wb_en, imem_valid}, 7'b1000000);
        run_task(3, 3'd1, 4'b0000, 0);
    endtask

    task automatic test_five_neighbors();
        run_task(10, 3'd2, 4'b0000, 1);
    endtask

    task automatic test_prev_output();
        run_task(20, 3'd3, 4'b0001, 2);
    endtask

    task automatic test_replay();
        run_task(30, 3'd6, 4'b1000, 0);
    endtask

    // full list, previous output and replay together
    task automatic test_random_grants();
        run_task(40, 3'd7, 4'b1001, 1);
    endtask

    task automatic test_back_to_back();
        run_task(50, 3'd4, 4'b0000, 3);
        run_task(51, 3'd5, 4'b0010, 3);
        run_task(3, 3'd0, 4'b0000, 0);  // zero again after large sums
    endtask

    initial begin : main
        int n, b;
        for (n = 0; n < (1 << `GNN_NODE_BITS); n++) begin
            for (b = 0; b < 3; b++) begin
                u_mem.feat0[n][b] = n * 7 + b * 31 + 1;
                u_mem.feat1[n][b] = (n * 13) ^ (b * 89) ^ 8'h5a;
            end
            u_mem.prev0[n] = 16'hff00 + n * 3;  // near the top so lane0 wraps
            u_mem.prev1[n] = n * 257;
        end
        set_list(3, 0, 0);
        set_list(10, 5, 40);
        set_list(20, 3, 7);
        set_list(30, 2, 99);
        set_list(40, 16, 5);
        set_list(50, 7, 60);
        set_list(51, 1, 77);
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        test_reset_empty();
        test_five_neighbors();
        test_prev_output();
        test_replay();
        test_random_grants();
        test_back_to_back();
        $display("sim passed");
        $finish;
    end

endmodule

//--- test/memory_model.sv
`timescale 1ns/100ps
`include "gnn_defines.svh"

module memory_model (
    input  logic                     clk,
    input  logic                     arb_req, out_req, wb_req,
    input  gnn_ctrl_pkg::req_type_t  arb_req_type,
    input  gnn_data_pkg::node_id_t   arb_node_id, out_node_id,
    output logic                     arb_grant, out_grant, wb_grant,
    output logic                     nbr_sos, nbr_eos, fv_sos, fv_eos, prev_sos, prev_eos,
    output gnn_data_pkg::nbr_count_t nbr_num,
    output gnn_data_pkg::node_id_t   nbr_id_lo, nbr_id_hi,
    output gnn_data_pkg::fv_lane_t   fv_lane0, fv_lane1,
    output gnn_data_pkg::lane_sum_t  prev_lane0, prev_lane1
);

    localparam int nodes    = 1 << `GNN_NODE_BITS;
    localparam int fv_beats = 3;  // sos, one middle beat, eos

    // tables, filled by the testbench
    int                      nbr_cnt [nodes];
    gnn_data_pkg::node_id_t  nbr_tab [nodes][`GNN_MAX_DEGREE];
    gnn_data_pkg::fv_lane_t  feat0   [nodes][`GNN_MAX_DEGREE/2];
    gnn_data_pkg::fv_lane_t  feat1   [nodes][`GNN_MAX_DEGREE/2];
    gnn_data_pkg::lane_sum_t prev0   [nodes];
    gnn_data_pkg::lane_sum_t prev1   [nodes];

    // granted requests in order
    gnn_ctrl_pkg::req_type_t log_type [64];
    gnn_data_pkg::node_id_t  log_node [64];
    gnn_data_pkg::node_id_t  out_node;
    int                      log_n, out_n, wb_n, hold_errs;
    int                      seed = 32'h56c0;

    wire [17:0] req_view = {arb_req, arb_req_type, arb_node_id, out_req, out_node_id, wb_req};

    // random grant delay, request levels and fields must not move meanwhile
    task automatic hold_for_grant();
        logic [17:0] first;
        first = req_view;
        repeat (1 + {$random(seed)} % 4) begin
            @(posedge clk);
            #2;
            if (req_view !== first) hold_errs++;
        end
    endtask

    task automatic stream(input logic is_list, input int n);
        int beats, b;
        beats = !is_list ? fv_beats : nbr_cnt[n] == 0 ? 1 : (nbr_cnt[n] + 1) / 2;
        for (b = 0; b < beats; b++) begin
            {nbr_sos, nbr_eos} = {is_list && b == 0, is_list && b == beats - 1};
            {fv_sos, fv_eos}   = {!is_list && b == 0, !is_list && b == beats - 1};
            nbr_num   = nbr_cnt[n];  // empty list still gets one beat
            nbr_id_lo = nbr_tab[n][2*b];
            nbr_id_hi = nbr_tab[n][2*b+1];
            fv_lane0  = feat0[n][b];
            fv_lane1  = feat1[n][b];
            @(posedge clk);
            #2;
        end
        {nbr_sos, nbr_eos, fv_sos, fv_eos} = 4'b0000;
    endtask

    initial begin
        {arb_grant, out_grant, wb_grant} = 3'b000;
        {nbr_sos, nbr_eos, fv_sos, fv_eos, prev_sos, prev_eos} = 6'b000000;
        nbr_num    = '0;
        nbr_id_lo  = '0;
        nbr_id_hi  = '0;
        fv_lane0   = '0;
        fv_lane1   = '0;
        prev_lane0 = '0;
        prev_lane1 = '0;
        forever begin
            @(posedge clk);
            #2;
            if (arb_req) begin
                hold_for_grant();
                log_type[log_n] = arb_req_type;
                log_node[log_n] = arb_node_id;
                arb_grant = 1'b1;
                @(posedge clk);
                #2;
                arb_grant = 1'b0;
                stream(log_type[log_n] == gnn_ctrl_pkg::req_nbr_list, log_node[log_n]);
                log_n++;
            end else if (out_req) begin
                hold_for_grant();
                out_node = out_node_id;
                out_n++;
                out_grant = 1'b1;
                @(posedge clk);
                #2;
                {out_grant, prev_sos, prev_eos} = 3'b011;  // single beat
                prev_lane0 = prev0[out_node];
                prev_lane1 = prev1[out_node];
                @(posedge clk);
                #2;
                {prev_sos, prev_eos} = 2'b00;
            end else if (wb_req) begin
                hold_for_grant();
                wb_n++;
                wb_grant = 1'b1;
                @(posedge clk);
                #2;
                wb_grant = 1'b0;
            end
        end
    end

endmodule
